//--- tb.f
common/csa_pkg.sv
rtl/stream_fifo.sv
csa_ram/csa_key_ram.sv
csa_ram/csa_key_arb.sv
csa_ram/csa_calc.sv
csa_ram/csa_dispatch.sv
csa_ram/csa_collect.sv
rtl/csa_wrap.sv
dv/csa_wrap_tb.sv

//--- Bender.yml
package:
  name: csa_wrap

sources:
  - common/csa_pkg.sv
  - rtl/stream_fifo.sv
  - csa_ram/csa_key_ram.sv
  - csa_ram/csa_key_arb.sv
  - csa_ram/csa_calc.sv
  - csa_ram/csa_dispatch.sv
  - csa_ram/csa_collect.sv
  - rtl/csa_wrap.sv
  - target: test
    files:
      - dv/csa_wrap_tb.sv

//--- dv/csa_wrap_tb.sv
`timescale 1ns/10ps

module csa_wrap_tb;

	localparam int CALC_NUM = 4;
	localparam int FIFO_DEPTH = 16;
	localparam int MAIN_JOBS = 200;
	localparam int TIMEOUT_CYCLES = MAIN_JOBS * 40 + 2000;
	localparam int KEY_WORDS = 1 << csa_pkg::KEY_ADDR_W;

	logic aclk;
	logic arst_n;
	logic wen;
	logic [csa_pkg::KEY_ADDR_W-1:0] waddr;
	logic [csa_pkg::BUS_W-1:0] wdata;
	logic ren;
	logic [csa_pkg::KEY_ADDR_W-1:0] raddr;
	logic [csa_pkg::BUS_W-1:0] rdata;
	logic in_wen;
	logic [csa_pkg::BUS_W-1:0] in_wdata;
	logic in_full;
	logic in_error_full;
	logic out_ren;
	logic [csa_pkg::BUS_W-1:0] out_rdata;
	logic out_ready;

	// Reference state
	logic [31:0] key_words [KEY_WORDS];
	logic [31:0] exp_hdr [256];
	logic [63:0] exp_res [256];
	bit exp_pend [256];
	logic [31:0] in_q [$];
	int cycle_cnt;

	csa_wrap #(
		.CALC_NUM(CALC_NUM),
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_csa_wrap (
		.aclk(aclk), .arst_n(arst_n),
		.wen(wen), .waddr(waddr), .wdata(wdata),
		.ren(ren), .raddr(raddr), .rdata(rdata),
		.in_wen(in_wen), .in_wdata(in_wdata), .in_full(in_full),
		.in_error_full(in_error_full),
		.out_ren(out_ren), .out_rdata(out_rdata), .out_ready(out_ready)
	);

	initial
	begin
		aclk = 1'b0;
		forever #5 aclk = ~aclk;
	end

	initial
	begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES)
		begin
			@(posedge aclk);
			cycle_cnt++;
		end
		$display("Timeout: the run did not complete within %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation finished: FAIL");
		$fatal(1, "Run stopped on timeout");
	end

	task automatic check_eq(input logic [63:0] actual, input logic [63:0] expected,
		input string msg);
		if (actual !== expected)
		begin
			$display("CHECK FAILED at %0t: %s (got %h, expected %h)", $time, msg,
				actual, expected);
			$display("Simulation finished: FAIL");
			$fatal(1, "Stopping at first error");
		end
	endtask

	// Eight rounds of xor, rotate left a byte, add round number to byte 0
	function automatic logic [63:0] scramble(input logic [63:0] data, input logic [63:0] key);
		logic [63:0] s;
		logic [63:0] x;
		s = data;
		for (int r = 0; r < 8; r++)
		begin
			x = s ^ key;
			s = {x[55:0], x[63:56]};
			s[7:0] = s[7:0] + 8'(r);
		end
		return s;
	endfunction

	task automatic bus_write(input int addr, input logic [31:0] data);
		@(posedge aclk);
		wen <= 1'b1;
		waddr <= csa_pkg::KEY_ADDR_W'(addr);
		wdata <= data;
		key_words[addr] = data;
		@(posedge aclk);
		wen <= 1'b0;
	endtask

	task automatic bus_read(input int addr, output logic [31:0] data);
		@(posedge aclk);
		ren <= 1'b1;
		raddr <= csa_pkg::KEY_ADDR_W'(addr);
		@(posedge aclk);
		ren <= 1'b0;
		@(posedge aclk);
		data = rdata;
	endtask

	task automatic queue_jobs(input int n_jobs, input int key_sel);
		logic [3:0] idx;
		logic [63:0] data;
		logic [31:0] hdr;
		for (int j = 0; j < n_jobs; j++)
		begin
			idx = (key_sel < 0) ? 4'($urandom_range(0, 15)) : 4'(key_sel);
			data = {$urandom(), $urandom()};
			hdr = '0;
			hdr[csa_pkg::HDR_TAG_LSB +: csa_pkg::TAG_W] = 8'(j);
			hdr[csa_pkg::HDR_KEY_LSB +: csa_pkg::KEY_IDX_W] = idx;
			exp_hdr[j] = hdr;
			exp_res[j] = scramble(data, {key_words[2*idx+1], key_words[2*idx]});
			exp_pend[j] = 1'b1;
			in_q.push_back(hdr);
			in_q.push_back(data[31:0]);
			in_q.push_back(data[63:32]);
		end
	endtask

	task automatic check_packet(input logic [31:0] hdr, input logic [31:0] lo,
		input logic [31:0] hi);
		logic [7:0] tag;
		tag = hdr[csa_pkg::HDR_TAG_LSB +: csa_pkg::TAG_W];
		check_eq(exp_pend[tag], 1'b1, $sformatf("tag %0d not pending", tag));
		check_eq(hdr, exp_hdr[tag], $sformatf("header for tag %0d", tag));
		check_eq(lo, exp_res[tag][31:0], $sformatf("result low for tag %0d", tag));
		check_eq(hi, exp_res[tag][63:32], $sformatf("result high for tag %0d", tag));
		exp_pend[tag] = 1'b0;
	endtask

	// Source and sink run together with strobes on every other cycle
	task automatic run_batch(input int n_jobs, input bit bp, input int key_sel);
		int got;
		int wcnt;
		int run_cnt;
		int stall_cnt;
		bit wr_hi;
		bit ren_hi;
		bit cap_next;
		bit saw_full;
		logic [31:0] pkt [3];
		got = 0;
		wcnt = 0;
		run_cnt = 0;
		stall_cnt = 0;
		wr_hi = 1'b0;
		ren_hi = 1'b0;
		cap_next = 1'b0;
		saw_full = 1'b0;
		queue_jobs(n_jobs, key_sel);
		while (got < n_jobs)
		begin
			@(posedge aclk);
			if (in_full)
				saw_full = 1'b1;
			if (wr_hi)
			begin
				in_wen <= 1'b0;
				wr_hi = 1'b0;
			end
			else if (in_q.size() > 0 && !in_full)
			begin
				in_wen <= 1'b1;
				in_wdata <= in_q.pop_front();
				wr_hi = 1'b1;
			end
			if (bp)
			begin
				if (stall_cnt > 0)
					stall_cnt--;
				else if (run_cnt > 0)
					run_cnt--;
				else
				begin
					run_cnt = $urandom_range(20, 60);
					stall_cnt = $urandom_range(40, 120);
				end
			end
			if (cap_next)
			begin
				pkt[wcnt] = out_rdata;
				wcnt++;
				cap_next = 1'b0;
				if (wcnt == 3)
				begin
					check_packet(pkt[0], pkt[1], pkt[2]);
					got++;
					wcnt = 0;
				end
			end
			if (ren_hi)
			begin
				out_ren <= 1'b0;
				ren_hi = 1'b0;
				cap_next = 1'b1;
			end
			else if (stall_cnt == 0 && out_ready)
			begin
				out_ren <= 1'b1;
				ren_hi = 1'b1;
			end
		end
		// Leftover words must stay in the output FIFO
		out_ren <= 1'b0;
		repeat (20) @(posedge aclk);
		check_eq(out_ready, 1'b0, "extra result words after the batch");
		check_eq(in_error_full, 1'b0, "overflow flag set during the batch");
		if (bp)
			check_eq(saw_full, 1'b1, "in_full never rose under back-pressure");
	endtask

	// Fill the input side with the output blocked, then push one word too many
	task automatic overflow_test();
		bit wr_hi;
		bit filled;
		wr_hi = 1'b0;
		filled = 1'b0;
		queue_jobs(30, -1);
		while (!filled)
		begin
			@(posedge aclk);
			if (wr_hi)
			begin
				in_wen <= 1'b0;
				wr_hi = 1'b0;
			end
			else if (in_full)
				filled = 1'b1;
			else
			begin
				in_wen <= 1'b1;
				in_wdata <= in_q.pop_front();
				wr_hi = 1'b1;
			end
		end
		repeat (50) @(posedge aclk);
		check_eq(in_full, 1'b1, "input FIFO did not stay full");
		check_eq(in_error_full, 1'b0, "overflow flag set before the extra write");
		in_wen <= 1'b1;
		in_wdata <= $urandom();
		@(posedge aclk);
		in_wen <= 1'b0;
		@(posedge aclk);
		check_eq(in_error_full, 1'b1, "overflow flag not set");
	endtask

	initial
	begin
		int seed_ret;
		int addr;
		int upd_idx;
		logic [31:0] rd;
		seed_ret = $urandom(32'h22531bbf);
		arst_n = 1'b0;
		wen = 1'b0;
		waddr = '0;
		wdata = '0;
		ren = 1'b0;
		raddr = '0;
		in_wen = 1'b0;
		in_wdata = '0;
		out_ren = 1'b0;
		repeat (5) @(posedge aclk);
		arst_n <= 1'b1;
		repeat (2) @(posedge aclk);

		// Fill the key memory and rewrite some words
		for (int a = 0; a < KEY_WORDS; a++)
			bus_write(a, $urandom());
		for (int n = 0; n < 20; n++)
		begin
			addr = $urandom_range(0, KEY_WORDS - 1);
			bus_write(addr, $urandom());
		end
		for (int a = 0; a < KEY_WORDS; a++)
		begin
			bus_read(a, rd);
			check_eq(rd, key_words[a], $sformatf("key memory word %0d", a));
		end

		run_batch(1, 1'b0, -1);
		run_batch(MAIN_JOBS, 1'b1, -1);

		upd_idx = $urandom_range(0, 15);
		bus_write(2 * upd_idx, $urandom());
		bus_write(2 * upd_idx + 1, $urandom());
		run_batch(12, 1'b0, upd_idx);

		overflow_test();

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

//--- rtl/csa_wrap.sv
`timescale 1ns/10ps

module csa_wrap #(
	parameter int CALC_NUM = 4,
	parameter int FIFO_DEPTH = 16
) (
	input  logic                              aclk,
	input  logic                              arst_n,
	input  logic                              wen,
	input  logic [csa_pkg::KEY_ADDR_W-1:0]    waddr,
	input  logic [csa_pkg::BUS_W-1:0]         wdata,
	input  logic                              ren,
	input  logic [csa_pkg::KEY_ADDR_W-1:0]    raddr,
	output logic [csa_pkg::BUS_W-1:0]         rdata,
	input  logic                              in_wen,
	input  logic [csa_pkg::BUS_W-1:0]         in_wdata,
	output logic                              in_full,
	output logic                              in_error_full,
	input  logic                              out_ren,
	output logic [csa_pkg::BUS_W-1:0]         out_rdata,
	output logic                              out_ready
);

	logic in_ren;
	logic [csa_pkg::BUS_W-1:0] in_rdata;
	logic in_r_ready;
	logic out_wen;
	logic [csa_pkg::BUS_W-1:0] out_wdata;
	logic [$clog2(FIFO_DEPTH):0] out_count;

	logic [CALC_NUM-1:0] start;
	logic [CALC_NUM-1:0] busy;
	logic [CALC_NUM-1:0] key_req;
	logic [CALC_NUM-1:0] key_gnt;
	logic [CALC_NUM-1:0] done;
	logic [CALC_NUM-1:0] take;
	logic key_ren;
	logic [csa_pkg::KEY_IDX_W-1:0] key_idx;
	logic [csa_pkg::KEY_W-1:0] key_data;
	logic [csa_pkg::KEY_IDX_W-1:0] job_key_idx;
	logic [csa_pkg::TAG_W-1:0] job_tag;
	logic [csa_pkg::KEY_W-1:0] job_data;
	logic [CALC_NUM*csa_pkg::KEY_IDX_W-1:0] calc_key_idx;
	logic [CALC_NUM*csa_pkg::TAG_W-1:0] res_tag_all;
	logic [CALC_NUM*csa_pkg::KEY_W-1:0] res_data_all;

	stream_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_in_fifo (
		.aclk(aclk), .arst_n(arst_n),
		.wen(in_wen), .wdata(in_wdata),
		.ren(in_ren), .rdata(in_rdata), .r_ready(in_r_ready),
		.full(in_full), .count(), .error_full(in_error_full)
	);

	stream_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_out_fifo (
		.aclk(aclk), .arst_n(arst_n),
		.wen(out_wen), .wdata(out_wdata),
		.ren(out_ren), .rdata(out_rdata), .r_ready(out_ready),
		.full(), .count(out_count), .error_full()
	);

	csa_key_ram u_key_ram (
		.aclk(aclk), .arst_n(arst_n),
		.wen(wen), .waddr(waddr), .wdata(wdata),
		.ren(ren), .raddr(raddr), .rdata(rdata),
		.key_ren(key_ren), .key_idx(key_idx), .key_data(key_data)
	);

	csa_key_arb #(.CALC_NUM(CALC_NUM)) u_key_arb (
		.aclk(aclk), .arst_n(arst_n),
		.key_req(key_req), .key_gnt(key_gnt),
		.key_ren(key_ren), .key_idx(key_idx), .req_idx(calc_key_idx)
	);

	csa_dispatch #(.CALC_NUM(CALC_NUM)) u_dispatch (
		.aclk(aclk), .arst_n(arst_n),
		.in_r_ready(in_r_ready), .in_ren(in_ren), .in_rdata(in_rdata),
		.busy(busy), .start(start),
		.job_key_idx(job_key_idx), .job_tag(job_tag), .job_data(job_data)
	);

	csa_collect #(.CALC_NUM(CALC_NUM), .FIFO_DEPTH(FIFO_DEPTH)) u_collect (
		.aclk(aclk), .arst_n(arst_n),
		.done(done), .res_tag_all(res_tag_all),
		.res_key_idx_all(calc_key_idx), .res_data_all(res_data_all),
		.take(take), .out_wen(out_wen), .out_wdata(out_wdata), .out_count(out_count)
	);

	for (genvar i = 0; i < CALC_NUM; i++)
	begin : g_calc
		csa_calc u_calc (
			.aclk(aclk), .arst_n(arst_n),
			.start(start[i]),
			.job_key_idx(job_key_idx), .job_tag(job_tag), .job_data(job_data),
			.busy(busy[i]),
			.key_req(key_req[i]), .key_gnt(key_gnt[i]), .key_data(key_data),
			.done(done[i]), .take(take[i]),
			.res_tag(res_tag_all[i*csa_pkg::TAG_W +: csa_pkg::TAG_W]),
			.res_data(res_data_all[i*csa_pkg::KEY_W +: csa_pkg::KEY_W]),
			.req_key_idx(calc_key_idx[i*csa_pkg::KEY_IDX_W +: csa_pkg::KEY_IDX_W])
		);
	end

endmodule

//--- csa_ram/csa_collect.sv
`timescale 1ns/10ps

module csa_collect #(
	parameter int CALC_NUM = 4,
	parameter int FIFO_DEPTH = 16
) (
	input  logic                                      aclk,
	input  logic                                      arst_n,
	input  logic [CALC_NUM-1:0]                       done,
	input  logic [CALC_NUM*csa_pkg::TAG_W-1:0]        res_tag_all,
	input  logic [CALC_NUM*csa_pkg::KEY_IDX_W-1:0]    res_key_idx_all,
	input  logic [CALC_NUM*csa_pkg::KEY_W-1:0]        res_data_all,
	output logic [CALC_NUM-1:0]                       take,
	output logic                                      out_wen,
	output logic [csa_pkg::BUS_W-1:0]                 out_wdata,
	input  logic [$clog2(FIFO_DEPTH):0]               out_count
);

	localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;

	localparam logic [1:0] C_IDLE = 2'd0;
	localparam logic [1:0] C_HDR = 2'd1;
	localparam logic [1:0] C_LO = 2'd2;
	localparam logic [1:0] C_HI = 2'd3;

	logic [1:0] state;
	logic [CALC_NUM-1:0] mask_q;
	logic [CALC_NUM-1:0] masked;
	logic [CALC_NUM-1:0] cand;
	logic [CALC_NUM-1:0] pick;
	logic room;
	logic [csa_pkg::TAG_W-1:0] sel_tag;
	logic [csa_pkg::KEY_IDX_W-1:0] sel_idx;
	logic [csa_pkg::KEY_W-1:0] sel_data;
	logic [csa_pkg::TAG_W-1:0] tag_q;
	logic [csa_pkg::KEY_IDX_W-1:0] idx_q;
	logic [csa_pkg::KEY_W-1:0] data_q;
	logic [csa_pkg::BUS_W-1:0] hdr;

	// Engines above the last one taken go first, then wrap around
	assign masked = done & mask_q;
	assign cand = (|masked) ? masked : done;
	assign pick = cand & (~cand + CALC_NUM'(1));
	assign room = out_count <= CNT_W'(FIFO_DEPTH - csa_pkg::PKT_WORDS);
	assign take = (state == C_IDLE && room) ? pick : '0;

	always_comb
	begin
		sel_tag = '0;
		sel_idx = '0;
		sel_data = '0;
		for (int i = 0; i < CALC_NUM; i++)
		begin
			if (pick[i])
			begin
				sel_tag = res_tag_all[i*csa_pkg::TAG_W +: csa_pkg::TAG_W];
				sel_idx = res_key_idx_all[i*csa_pkg::KEY_IDX_W +: csa_pkg::KEY_IDX_W];
				sel_data = res_data_all[i*csa_pkg::KEY_W +: csa_pkg::KEY_W];
			end
		end
	end

	always_ff @(posedge aclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= C_IDLE;
			mask_q <= '1;
		end
		else
		begin
			case (state)
				C_IDLE:
					if (|take)
					begin
						mask_q <= ~(take | (take - CALC_NUM'(1)));
						state <= C_HDR;
					end
				C_HDR:
					state <= C_LO;
				C_LO:
					state <= C_HI;
				default:
					state <= C_IDLE;
			endcase
		end
	end

	// Engine may be restarted while the packet is still going out
	always_ff @(posedge aclk)
	begin
		if (|take)
		begin
			tag_q <= sel_tag;
			idx_q <= sel_idx;
			data_q <= sel_data;
		end
	end

	always_comb
	begin
		hdr = '0;
		hdr[csa_pkg::HDR_TAG_LSB +: csa_pkg::TAG_W] = tag_q;
		hdr[csa_pkg::HDR_KEY_LSB +: csa_pkg::KEY_IDX_W] = idx_q;
	end

	assign out_wen = state != C_IDLE;

	always_comb
	begin
		case (state)
			C_HDR: out_wdata = hdr;
			C_LO: out_wdata = data_q[csa_pkg::BUS_W-1:0];
			default: out_wdata = data_q[csa_pkg::KEY_W-1:csa_pkg::BUS_W];
		endcase
	end

endmodule

//--- csa_ram/csa_dispatch.sv
`timescale 1ns/10ps

module csa_dispatch #(
	parameter int CALC_NUM = 4
) (
	input  logic                              aclk,
	input  logic                              arst_n,
	input  logic                              in_r_ready,
	output logic                              in_ren,
	input  logic [csa_pkg::BUS_W-1:0]         in_rdata,
	input  logic [CALC_NUM-1:0]               busy,
	output logic [CALC_NUM-1:0]               start,
	output logic [csa_pkg::KEY_IDX_W-1:0]     job_key_idx,
	output logic [csa_pkg::TAG_W-1:0]         job_tag,
	output logic [csa_pkg::KEY_W-1:0]         job_data
);

	localparam int WCNT_W = $clog2(csa_pkg::PKT_WORDS);

	localparam logic [1:0] D_POP = 2'd0;
	localparam logic [1:0] D_CAP = 2'd1;
	localparam logic [1:0] D_START = 2'd2;

	logic [1:0] state;
	logic [WCNT_W-1:0] wcnt;
	logic [csa_pkg::BUS_W-1:0] pkt_q [csa_pkg::PKT_WORDS];
	logic [CALC_NUM-1:0] idle;
	logic [CALC_NUM-1:0] pick;

	// Lowest idle engine wins
	assign idle = ~busy;
	assign pick = idle & (~idle + CALC_NUM'(1));

	assign in_ren = (state == D_POP) && in_r_ready;
	assign start = (state == D_START) ? pick : '0;

	always_ff @(posedge aclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= D_POP;
			wcnt <= '0;
		end
		else
		begin
			case (state)
				D_POP:
					if (in_r_ready)
						state <= D_CAP;
				D_CAP:
				begin
					if (wcnt == WCNT_W'(csa_pkg::PKT_WORDS - 1))
					begin
						wcnt <= '0;
						state <= D_START;
					end
					else
					begin
						wcnt <= wcnt + 1'b1;
						state <= D_POP;
					end
				end
				D_START:
					if (|idle)
						state <= D_POP;
				default:
					state <= D_POP;
			endcase
		end
	end

	always_ff @(posedge aclk)
	begin
		if (state == D_CAP)
			pkt_q[wcnt] <= in_rdata;
	end

	assign job_tag = pkt_q[0][csa_pkg::HDR_TAG_LSB +: csa_pkg::TAG_W];
	assign job_key_idx = pkt_q[0][csa_pkg::HDR_KEY_LSB +: csa_pkg::KEY_IDX_W];
	assign job_data = {pkt_q[2], pkt_q[1]};

endmodule

//--- csa_ram/csa_calc.sv
`timescale 1ns/10ps

module csa_calc (
	input  logic                              aclk,
	input  logic                              arst_n,
	input  logic                              start,
	input  logic [csa_pkg::KEY_IDX_W-1:0]     job_key_idx,
	input  logic [csa_pkg::TAG_W-1:0]         job_tag,
	input  logic [csa_pkg::KEY_W-1:0]         job_data,
	output logic                              busy,
	output logic                              key_req,
	input  logic                              key_gnt,
	input  logic [csa_pkg::KEY_W-1:0]         key_data,
	output logic                              done,
	input  logic                              take,
	output logic [csa_pkg::TAG_W-1:0]         res_tag,
	output logic [csa_pkg::KEY_W-1:0]         res_data,
	output logic [csa_pkg::KEY_IDX_W-1:0]     req_key_idx
);

	localparam int RND_W = $clog2(csa_pkg::ROUNDS);

	localparam logic [2:0] S_IDLE = 3'd0;
	localparam logic [2:0] S_REQ = 3'd1;
	localparam logic [2:0] S_KWAIT = 3'd2;
	localparam logic [2:0] S_ROUND = 3'd3;
	localparam logic [2:0] S_DONE = 3'd4;

	logic [2:0] state;
	logic [RND_W-1:0] round_q;
	logic [csa_pkg::TAG_W-1:0] tag_q;
	logic [csa_pkg::KEY_IDX_W-1:0] idx_q;
	csa_pkg::csa_key_u data_q;
	csa_pkg::csa_key_u key_q;
	csa_pkg::csa_key_u xored;
	csa_pkg::csa_key_u mixed;

	// One round: xor key, rotate left a byte, add round number to byte 0
	always_comb
	begin
		xored = data_q ^ key_q;
		mixed.bytes[0] = xored.bytes[7] + 8'(round_q);
		for (int i = 1; i < 8; i++)
			mixed.bytes[i] = xored.bytes[i-1];
	end

	always_ff @(posedge aclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= S_IDLE;
			round_q <= '0;
		end
		else
		begin
			case (state)
				S_IDLE:
					if (start)
						state <= S_REQ;
				S_REQ:
					if (key_gnt)
						state <= S_KWAIT;
				S_KWAIT:
				begin
					round_q <= '0;
					state <= S_ROUND;
				end
				S_ROUND:
				begin
					round_q <= round_q + 1'b1;
					if (round_q == RND_W'(csa_pkg::ROUNDS - 1))
						state <= S_DONE;
				end
				S_DONE:
					if (take)
						state <= S_IDLE;
				default:
					state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge aclk)
	begin
		if (state == S_IDLE && start)
		begin
			tag_q <= job_tag;
			idx_q <= job_key_idx;
			data_q <= job_data;
		end
		// Key word shows up the cycle after the grant
		if (state == S_KWAIT)
			key_q <= key_data;
		if (state == S_ROUND)
			data_q <= mixed;
	end

	assign busy = state != S_IDLE;
	assign key_req = state == S_REQ;
	assign done = state == S_DONE;
	assign res_tag = tag_q;
	assign res_data = data_q;
	assign req_key_idx = idx_q;

	// Dispatcher only picks idle engines
	a_start_idle: assert property (@(posedge aclk) disable iff (!arst_n)
		start |-> !busy);

endmodule

//--- csa_ram/csa_key_arb.sv
`timescale 1ns/10ps

module csa_key_arb #(
	parameter int CALC_NUM = 4
) (
	input  logic                                      aclk,
	input  logic                                      arst_n,
	input  logic [CALC_NUM-1:0]                       key_req,
	output logic [CALC_NUM-1:0]                       key_gnt,
	output logic                                      key_ren,
	output logic [csa_pkg::KEY_IDX_W-1:0]             key_idx,
	input  logic [CALC_NUM*csa_pkg::KEY_IDX_W-1:0]    req_idx
);

	localparam int IDX_W = (CALC_NUM > 1) ? $clog2(CALC_NUM) : 1;

	logic [IDX_W-1:0] last_q;
	logic [IDX_W-1:0] win;
	logic found;

	// Search starts just after the last winner
	always_comb
	begin
		key_gnt = '0;
		win = '0;
		found = 1'b0;
		for (int i = 1; i <= CALC_NUM; i++)
		begin
			if (!found && key_req[(int'(last_q) + i) % CALC_NUM])
			begin
				found = 1'b1;
				win = IDX_W'((int'(last_q) + i) % CALC_NUM);
			end
		end
		if (found)
			key_gnt[win] = 1'b1;
	end

	assign key_ren = found;
	assign key_idx = req_idx[win*csa_pkg::KEY_IDX_W +: csa_pkg::KEY_IDX_W];

	always_ff @(posedge aclk or negedge arst_n)
	begin
		if (!arst_n)
			last_q <= IDX_W'(CALC_NUM - 1);
		else if (found)
			last_q <= win;
	end

	a_gnt_onehot: assert property (@(posedge aclk) disable iff (!arst_n)
		$onehot0(key_gnt));

endmodule

//--- csa_ram/csa_key_ram.sv
`timescale 1ns/10ps

module csa_key_ram (
	input  logic                              aclk,
	input  logic                              arst_n,
	input  logic                              wen,
	input  logic [csa_pkg::KEY_ADDR_W-1:0]    waddr,
	input  logic [csa_pkg::BUS_W-1:0]         wdata,
	input  logic                              ren,
	input  logic [csa_pkg::KEY_ADDR_W-1:0]    raddr,
	output logic [csa_pkg::BUS_W-1:0]         rdata,
	input  logic                              key_ren,
	input  logic [csa_pkg::KEY_IDX_W-1:0]     key_idx,
	output logic [csa_pkg::KEY_W-1:0]         key_data
);

	csa_pkg::csa_key_u keys [csa_pkg::KEY_NUM];
	csa_pkg::csa_key_u rd_key;

	assign rd_key = keys[raddr[csa_pkg::KEY_ADDR_W-1:1]];

	always_ff @(posedge aclk)
	begin
		if (wen)
		begin
			if (waddr[0])
				keys[waddr[csa_pkg::KEY_ADDR_W-1:1]].half.hi <= wdata;
			else
				keys[waddr[csa_pkg::KEY_ADDR_W-1:1]].half.lo <= wdata;
		end
	end

	always_ff @(posedge aclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rdata <= '0;
			key_data <= '0;
		end
		else
		begin
			if (ren)
				rdata <= raddr[0] ? rd_key.half.hi : rd_key.half.lo;
			if (key_ren)
				key_data <= keys[key_idx];
		end
	end

endmodule

//--- rtl/stream_fifo.sv
`timescale 1ns/10ps

module stream_fifo #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic                          aclk,
	input  logic                          arst_n,
	input  logic                          wen,
	input  logic [csa_pkg::BUS_W-1:0]     wdata,
	input  logic                          ren,
	output logic [csa_pkg::BUS_W-1:0]     rdata,
	output logic                          r_ready,
	output logic                          full,
	output logic [$clog2(FIFO_DEPTH):0]   count,
	output logic                          error_full
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = PTR_W + 1;

	logic [csa_pkg::BUS_W-1:0] mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic do_wr;
	logic do_rd;

	assign r_ready = count != '0;
	assign full = count == CNT_W'(FIFO_DEPTH);
	assign do_wr = wen && !full;
	assign do_rd = ren && r_ready;

	always_ff @(posedge aclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			error_full <= 1'b0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (!do_wr && do_rd)
				count <= count - 1'b1;
			// Sticky, the dropped word is lost
			if (wen && full)
				error_full <= 1'b1;
		end
	end

	always_ff @(posedge aclk)
	begin
		if (do_wr)
			mem[wr_ptr] <= wdata;
		if (do_rd)
			rdata <= mem[rd_ptr];
	end

	// The reader looks at r_ready before it pops
	a_no_read_empty: assert property (@(posedge aclk) disable iff (!arst_n)
		ren |-> r_ready);

endmodule

//--- common/csa_pkg.sv
package csa_pkg;

	localparam int BUS_W = 32;
	localparam int KEY_W = 64;
	localparam int KEY_IDX_W = 4;
	localparam int KEY_NUM = 1 << KEY_IDX_W;
	// Two bus words per key, odd address is the high half
	localparam int KEY_ADDR_W = 5;
	localparam int TAG_W = 8;

	localparam int PKT_WORDS = 3;
	localparam int ROUNDS = 8;

	// Job header word
	localparam int HDR_TAG_LSB = 0;
	localparam int HDR_KEY_LSB = 8;

	// Bus side sees halves, the round function sees bytes
	typedef union packed {
		struct packed {
			logic [BUS_W-1:0] hi;
			logic [BUS_W-1:0] lo;
		} half;
		logic [7:0][7:0] bytes;
	} csa_key_u;

endpackage
